//--- src/pinmux_pkg.sv
// ------------------------------------------------
// Shared types for the 32-pad GPIO pin multiplexer
// Pad k is port bit k; only pads 0-31 exist
// ------------------------------------------------
package pinmux_pkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------
  localparam int PORT_W   = 8;
  // Four ports, A to D
  localparam int NUM_PADS = 4 * PORT_W;
  localparam int APB_AW   = 4;
  localparam int APB_DW   = 32;
  localparam int NUM_PWM  = 6;
  localparam int NUM_CS   = 4;
  localparam int NUM_UART = 2;
  localparam int NUM_INT  = 2;

  // Alternate-function pads, port D
  localparam int PAD_RXD0      = 24;
  localparam int PAD_TXD0      = 25;
  localparam int PAD_RXD1_INT0 = 26;
  localparam int PAD_PWM0_INT1 = 27;
  localparam int PAD_TXD1      = 28;
  localparam int PAD_PWM1_CS3  = 29;
  localparam int PAD_PWM2_CS2  = 30;
  // Alternate-function pads, port B
  localparam int PAD_PWM3_CS1  = 9;
  localparam int PAD_PWM4_CS0  = 10;
  localparam int PAD_PWM5      = 11;

  // Register byte offsets
  typedef enum logic [APB_AW-1:0] {
    REG_GPIO_DIR = 4'h0,
    REG_GPIO_OUT = 4'h4,
    REG_FUNC_SEL = 4'h8,
    REG_GPIO_IN  = 4'hc
  } reg_addr_e;

  // ------------------------------------------------
  // Bundles
  // ------------------------------------------------
  // FUNC_SEL[13:0], msb field first
  typedef struct packed {
    logic [NUM_CS-1:0]   cs_enb;
    logic [NUM_UART-1:0] uart_enb;
    logic [NUM_INT-1:0]  int_enb;
    logic [NUM_PWM-1:0]  pwm_enb;
  } func_sel_t;

  typedef struct packed {
    logic [NUM_PADS-1:0] gpio_dir;
    logic [NUM_PADS-1:0] gpio_out;
    func_sel_t           func;
  } pin_cfg_t;

  // oen of 1 leaves the pad as an input
  typedef struct packed {
    logic [NUM_PADS-1:0] pad_out;
    logic [NUM_PADS-1:0] pad_oen;
  } pad_bus_t;

  // Peripheral outputs toward the pads
  typedef struct packed {
    logic [NUM_UART-1:0] uart_txd;
    logic [NUM_PWM-1:0]  pwm_wfm;
    logic [NUM_CS-1:0]   spim_ssn;
  } periph_out_t;

  // Pad inputs toward the peripherals
  typedef struct packed {
    logic [NUM_UART-1:0] uart_rxd;
    logic [NUM_INT-1:0]  ext_intr;
  } periph_in_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

endpackage

//--- src/pinmux_regs.sv
// ------------------------------------------------
// APB slave, no wait states; writes land at the
// access-phase edge. FUNC_SEL keeps bits 13:0 only
// ------------------------------------------------
module pinmux_regs import pinmux_pkg::*; (
  input  logic                app_clk_i,
  input  logic                reset_i,
  input  apb_req_t            apb_req_i,
  output apb_rsp_t            apb_rsp_o,
  input  logic [NUM_PADS-1:0] pad_gpio_in_i,
  output pin_cfg_t            cfg_o
);

  // ------------------------------------------------
  // Decode
  // ------------------------------------------------
  reg_addr_e         addr;
  logic              access;
  logic              addr_hit;
  logic              ro_write;
  logic              wr_en;
  logic [APB_DW-1:0] rd_data;

  // Stored configuration
  pin_cfg_t cfg_q;

  assign addr   = reg_addr_e'(apb_req_i.paddr);
  // Second cycle of the transfer
  assign access = apb_req_i.psel & apb_req_i.penable;

  always_comb begin
    addr_hit = 1'b1;
    rd_data  = '0;
    case (addr)
      REG_GPIO_DIR: rd_data = cfg_q.gpio_dir;
      REG_GPIO_OUT: rd_data = cfg_q.gpio_out;
      // Upper bits zero filled
      REG_FUNC_SEL: rd_data = APB_DW'(cfg_q.func);
      REG_GPIO_IN:  rd_data = pad_gpio_in_i;
      default: begin
        addr_hit = 1'b0;
      end
    endcase
  end

  // Input readback is read only
  assign ro_write = apb_req_i.pwrite & (addr == REG_GPIO_IN);

  // Only legal writes touch the registers
  assign wr_en = access & apb_req_i.pwrite & addr_hit & ~ro_write;

  // ------------------------------------------------
  // Registers
  // ------------------------------------------------
  always_ff @(posedge app_clk_i) begin
    if (reset_i) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      case (addr)
        REG_GPIO_DIR: cfg_q.gpio_dir <= apb_req_i.pwdata;
        REG_GPIO_OUT: cfg_q.gpio_out <= apb_req_i.pwdata;
        // Drop the unused upper bits
        REG_FUNC_SEL: cfg_q.func <= func_sel_t'(apb_req_i.pwdata[$bits(func_sel_t)-1:0]);
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  // ------------------------------------------------
  // Response
  // ------------------------------------------------
  // Always ready in the access phase
  assign apb_rsp_o.pready  = access;

  // Bad address or write to GPIO_IN
  assign apb_rsp_o.pslverr = access & (~addr_hit | ro_write);

  // Read data only shown while the slave is selected
  assign apb_rsp_o.prdata  = apb_req_i.psel ? rd_data : '0;

  assign cfg_o = cfg_q;

endmodule

//--- src/pad_out_mux.sv
// ------------------------------------------------
// Combinational pad driver, no registers
// Priority: PWM, SPI CS, UART, interrupt, GPIO
// ------------------------------------------------
module pad_out_mux import pinmux_pkg::*; (
  input  pin_cfg_t    cfg_i,
  input  periph_out_t periph_i,
  output pad_bus_t    pads_o
);

  func_sel_t fs;

  assign fs = cfg_i.func;

  always_comb begin
    // ------------------------------------------------
    // Plain GPIO, lowest priority
    // ------------------------------------------------
    for (int k = 0; k < NUM_PADS; k++) begin
      pads_o.pad_oen[k] = ~cfg_i.gpio_dir[k];
      pads_o.pad_out[k] = cfg_i.gpio_dir[k] & cfg_i.gpio_out[k];
    end

    // ------------------------------------------------
    // Port D alternate functions
    // ------------------------------------------------
    // UART0 receive takes the pad as input
    if (fs.uart_enb[0]) begin
      pads_o.pad_oen[PAD_RXD0] = 1'b1;
      pads_o.pad_out[PAD_RXD0] = 1'b0;
    end

    // UART0 transmit
    if (fs.uart_enb[0]) begin
      pads_o.pad_oen[PAD_TXD0] = 1'b0;
      pads_o.pad_out[PAD_TXD0] = periph_i.uart_txd[0];
    end

    // RXD1 or INT0, both inputs
    if (fs.uart_enb[1] || fs.int_enb[0]) begin
      pads_o.pad_oen[PAD_RXD1_INT0] = 1'b1;
      pads_o.pad_out[PAD_RXD1_INT0] = 1'b0;
    end

    // PWM0 wins over INT1
    if (fs.pwm_enb[0]) begin
      pads_o.pad_oen[PAD_PWM0_INT1] = 1'b0;
      pads_o.pad_out[PAD_PWM0_INT1] = periph_i.pwm_wfm[0];
    end else if (fs.int_enb[1]) begin
      pads_o.pad_oen[PAD_PWM0_INT1] = 1'b1;
      pads_o.pad_out[PAD_PWM0_INT1] = 1'b0;
    end

    // UART1 transmit
    if (fs.uart_enb[1]) begin
      pads_o.pad_oen[PAD_TXD1] = 1'b0;
      pads_o.pad_out[PAD_TXD1] = periph_i.uart_txd[1];
    end

    // Shared PWM and chip select, PWM first
    if (fs.pwm_enb[1] || fs.cs_enb[3]) begin
      pads_o.pad_oen[PAD_PWM1_CS3] = 1'b0;
      pads_o.pad_out[PAD_PWM1_CS3] = fs.pwm_enb[1] ? periph_i.pwm_wfm[1] : periph_i.spim_ssn[3];
    end

    if (fs.pwm_enb[2] || fs.cs_enb[2]) begin
      pads_o.pad_oen[PAD_PWM2_CS2] = 1'b0;
      pads_o.pad_out[PAD_PWM2_CS2] = fs.pwm_enb[2] ? periph_i.pwm_wfm[2] : periph_i.spim_ssn[2];
    end

    // ------------------------------------------------
    // Port B alternate functions
    // ------------------------------------------------
    if (fs.pwm_enb[3] || fs.cs_enb[1]) begin
      pads_o.pad_oen[PAD_PWM3_CS1] = 1'b0;
      pads_o.pad_out[PAD_PWM3_CS1] = fs.pwm_enb[3] ? periph_i.pwm_wfm[3] : periph_i.spim_ssn[1];
    end

    if (fs.pwm_enb[4] || fs.cs_enb[0]) begin
      pads_o.pad_oen[PAD_PWM4_CS0] = 1'b0;
      pads_o.pad_out[PAD_PWM4_CS0] = fs.pwm_enb[4] ? periph_i.pwm_wfm[4] : periph_i.spim_ssn[0];
    end

    // PWM5 only
    if (fs.pwm_enb[5]) begin
      pads_o.pad_oen[PAD_PWM5] = 1'b0;
      pads_o.pad_out[PAD_PWM5] = periph_i.pwm_wfm[5];
    end
  end

endmodule

//--- src/pad_in_route.sv
// ------------------------------------------------
// Pad inputs reach peripherals after two edges
// Disabled UART inputs idle high, interrupts low
// ------------------------------------------------
module pad_in_route import pinmux_pkg::*; (
  input  logic                app_clk_i,
  input  logic                reset_i,
  input  logic [NUM_PADS-1:0] pad_in_i,
  input  pin_cfg_t            cfg_i,
  output logic [NUM_PADS-1:0] pad_gpio_in_o,
  output periph_in_t          periph_o
);

  // ------------------------------------------------
  // Two-flop synchronizer
  // ------------------------------------------------
  logic [NUM_PADS-1:0] meta_q;
  logic [NUM_PADS-1:0] sync_q;
  func_sel_t           fs;

  always_ff @(posedge app_clk_i) begin
    if (reset_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= pad_in_i;
      sync_q <= meta_q;
    end
  end

  // All pads readable regardless of function
  assign pad_gpio_in_o = sync_q;

  // ------------------------------------------------
  // Peripheral routing
  // ------------------------------------------------
  assign fs = cfg_i.func;

  // UART receive lines
  assign periph_o.uart_rxd[0] = fs.uart_enb[0] ? sync_q[PAD_RXD0] : 1'b1;
  assign periph_o.uart_rxd[1] = fs.uart_enb[1] ? sync_q[PAD_RXD1_INT0] : 1'b1;

  // INT0 loses its pad to RXD1
  assign periph_o.ext_intr[0] = fs.int_enb[0] & ~fs.uart_enb[1] & sync_q[PAD_RXD1_INT0];

  // Level interrupt, even while PWM0 drives the pad
  assign periph_o.ext_intr[1] = fs.int_enb[1] & sync_q[PAD_PWM0_INT1];

endmodule

//--- src/pinmux_top.sv
// ------------------------------------------------
// Pin mux top; config one edge, inputs two edges
// ------------------------------------------------
module pinmux_top import pinmux_pkg::*; (
  input  logic                app_clk_i,
  input  logic                reset_i,
  input  apb_req_t            apb_req_i,
  output apb_rsp_t            apb_rsp_o,
  input  periph_out_t         periph_i,
  output periph_in_t          periph_o,
  input  logic [NUM_PADS-1:0] pad_in_i,
  output pad_bus_t            pads_o
);

  pin_cfg_t            cfg;
  logic [NUM_PADS-1:0] pad_gpio_in;

  // Config registers and APB
  pinmux_regs u_regs (
    .app_clk_i     (app_clk_i),
    .reset_i       (reset_i),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .pad_gpio_in_i (pad_gpio_in),
    .cfg_o         (cfg)
  );

  // Output side
  pad_out_mux u_out_mux (
    .cfg_i    (cfg),
    .periph_i (periph_i),
    .pads_o   (pads_o)
  );

  // Input side
  pad_in_route u_in_route (
    .app_clk_i     (app_clk_i),
    .reset_i       (reset_i),
    .pad_in_i      (pad_in_i),
    .cfg_i         (cfg),
    .pad_gpio_in_o (pad_gpio_in),
    .periph_o      (periph_o)
  );

endmodule

//--- tests/pinmux_ref.svh
// ------------------------------------------------
// Expected pad and peripheral values for the pin mux
// Included inside the testbench after the package import
// ------------------------------------------------
`ifndef PINMUX_REF_SVH
`define PINMUX_REF_SVH

// Pad drivers and directions, lowest priority applied first
function automatic pad_bus_t ref_pads(pin_cfg_t cfg, periph_out_t p);
  pad_bus_t            r;
  func_sel_t           f;
  logic [NUM_PADS-1:0] drv_en;
  logic [NUM_PADS-1:0] drv_val;
  logic [NUM_PADS-1:0] in_en;
  f       = cfg.func;
  drv_en  = '0;
  drv_val = '0;
  in_en   = '0;
  // Level interrupts take their pads as inputs
  if (f.int_enb[0]) in_en[PAD_RXD1_INT0] = 1'b1;
  if (f.int_enb[1]) in_en[PAD_PWM0_INT1] = 1'b1;
  // UART pairs
  if (f.uart_enb[0]) begin
    in_en[PAD_RXD0]   = 1'b1;
    drv_en[PAD_TXD0]  = 1'b1;
    drv_val[PAD_TXD0] = p.uart_txd[0];
  end
  if (f.uart_enb[1]) begin
    in_en[PAD_RXD1_INT0] = 1'b1;
    drv_en[PAD_TXD1]     = 1'b1;
    drv_val[PAD_TXD1]    = p.uart_txd[1];
  end
  // Chip selects, then PWM on top of them
  if (f.cs_enb[3]) {drv_en[PAD_PWM1_CS3], drv_val[PAD_PWM1_CS3]} = {1'b1, p.spim_ssn[3]};
  if (f.cs_enb[2]) {drv_en[PAD_PWM2_CS2], drv_val[PAD_PWM2_CS2]} = {1'b1, p.spim_ssn[2]};
  if (f.cs_enb[1]) {drv_en[PAD_PWM3_CS1], drv_val[PAD_PWM3_CS1]} = {1'b1, p.spim_ssn[1]};
  if (f.cs_enb[0]) {drv_en[PAD_PWM4_CS0], drv_val[PAD_PWM4_CS0]} = {1'b1, p.spim_ssn[0]};
  if (f.pwm_enb[0]) {drv_en[PAD_PWM0_INT1], drv_val[PAD_PWM0_INT1]} = {1'b1, p.pwm_wfm[0]};
  if (f.pwm_enb[1]) {drv_en[PAD_PWM1_CS3], drv_val[PAD_PWM1_CS3]} = {1'b1, p.pwm_wfm[1]};
  if (f.pwm_enb[2]) {drv_en[PAD_PWM2_CS2], drv_val[PAD_PWM2_CS2]} = {1'b1, p.pwm_wfm[2]};
  if (f.pwm_enb[3]) {drv_en[PAD_PWM3_CS1], drv_val[PAD_PWM3_CS1]} = {1'b1, p.pwm_wfm[3]};
  if (f.pwm_enb[4]) {drv_en[PAD_PWM4_CS0], drv_val[PAD_PWM4_CS0]} = {1'b1, p.pwm_wfm[4]};
  if (f.pwm_enb[5]) {drv_en[PAD_PWM5], drv_val[PAD_PWM5]} = {1'b1, p.pwm_wfm[5]};
  // A driving function beats an input function beats GPIO
  r.pad_oen = ~drv_en & (in_en | ~cfg.gpio_dir);
  r.pad_out = (drv_en & drv_val) | (~drv_en & ~in_en & cfg.gpio_dir & cfg.gpio_out);
  return r;
endfunction

// Peripheral inputs from synchronized pad levels
function automatic periph_in_t ref_periph_in(pin_cfg_t cfg, logic [NUM_PADS-1:0] pins);
  periph_in_t r;
  r.uart_rxd[0] = cfg.func.uart_enb[0] ? pins[PAD_RXD0] : 1'b1;
  r.uart_rxd[1] = cfg.func.uart_enb[1] ? pins[PAD_RXD1_INT0] : 1'b1;
  r.ext_intr[0] = (cfg.func.int_enb[0] && !cfg.func.uart_enb[1]) ? pins[PAD_RXD1_INT0] : 1'b0;
  r.ext_intr[1] = cfg.func.int_enb[1] ? pins[PAD_PWM0_INT1] : 1'b0;
  return r;
endfunction

`endif

//--- tests/pinmux_tb.sv
// ------------------------------------------------
// Pin mux testbench that stops at the first mismatch
// ------------------------------------------------
module pinmux_tb import pinmux_pkg::*; ();

  `include "pinmux_ref.svh"

  localparam int N_GPIO  = 20;
  localparam int N_ALT   = 200;
  localparam int N_IN    = 40;
  // Cycle budget summed over the tests in run order
  localparam int RUN_CYC = 6 + 16 + 40 + N_GPIO * 8 + N_ALT * 11 + N_IN * 10;

  logic                clk;
  logic                reset;
  apb_req_t            req;
  apb_rsp_t            rsp;
  periph_out_t         p_out;
  periph_in_t          p_in;
  logic [NUM_PADS-1:0] pad_in;
  pad_bus_t            pads;
  // Mirror of the committed configuration
  pin_cfg_t            cfg_model;
  string               test_name;
  logic                check_en;

  pinmux_top dut0 (
    .app_clk_i (clk),
    .reset_i   (reset),
    .apb_req_i (req),
    .apb_rsp_o (rsp),
    .periph_i  (p_out),
    .periph_o  (p_in),
    .pad_in_i  (pad_in),
    .pads_o    (pads)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------
  // Compare tasks
  // ------------------------------------------------
  task automatic abort_run(string why);
    $display("tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_pads(string name, pad_bus_t exp, pad_bus_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run("pad outputs differ");
    end
  endtask

  task automatic check_periph_in(string name, periph_in_t exp, periph_in_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run("peripheral inputs differ");
    end
  endtask

  task automatic check_rdata(string name, logic [APB_DW-1:0] exp, logic [APB_DW-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run("APB read data differs");
    end
  endtask

  task automatic check_slverr(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run("APB error flag differs");
    end
  endtask

  task automatic check_ready(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run("APB ready flag differs");
    end
  endtask

  // ------------------------------------------------
  // APB transfers
  // ------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata,
                          output logic [APB_DW-1:0] rdata, output logic err);
    @(negedge clk);
    req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    // Setup phase gives no ready and no error
    #1;
    check_ready(test_name, 1'b0, rsp.pready);
    check_slverr(test_name, 1'b0, rsp.pslverr);
    @(negedge clk);
    req.penable = 1'b1;
    // Response settled in the middle of the low phase
    #1;
    check_ready(test_name, 1'b1, rsp.pready);
    rdata = rsp.prdata;
    err   = rsp.pslverr;
    @(posedge clk);
    // Commit edge of the write
    if (wr) begin
      case (addr)
        REG_GPIO_DIR: cfg_model.gpio_dir = wdata;
        REG_GPIO_OUT: cfg_model.gpio_out = wdata;
        REG_FUNC_SEL: cfg_model.func = func_sel_t'(wdata[$bits(func_sel_t)-1:0]);
        default: ;
      endcase
    end
    @(negedge clk);
    req = '0;
  endtask

  task automatic write_reg(string name, logic [APB_AW-1:0] a, logic [APB_DW-1:0] d,
                           logic exp_err);
    logic [APB_DW-1:0] rd;
    logic              err;
    apb_xfer(1'b1, a, d, rd, err);
    check_slverr(name, exp_err, err);
  endtask

  task automatic read_reg(string name, logic [APB_AW-1:0] a, logic [APB_DW-1:0] exp,
                          logic exp_err);
    logic [APB_DW-1:0] rd;
    logic              err;
    apb_xfer(1'b0, a, '0, rd, err);
    check_slverr(name, exp_err, err);
    if (!exp_err) check_rdata(name, exp, rd);
  endtask

  // Pads checked one time unit after every rising edge
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (check_en) check_pads(test_name, ref_pads(cfg_model, p_out), pads);
    end
  end

  // Watchdog
  initial begin
    #(RUN_CYC * 4 * 2);
    abort_run("watchdog timeout, the tests did not finish in time");
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  initial begin
    logic [APB_DW-1:0]   rnd;
    logic [NUM_PADS-1:0] prev;
    void'($urandom(32'hb58f));
    reset     = 1'b1;
    req       = '0;
    p_out     = '0;
    pad_in    = '0;
    cfg_model = '0;
    check_en  = 1'b0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Reset state
    #1;
    check_pads(test_name, '{pad_out: '0, pad_oen: '1}, pads);
    check_periph_in(test_name, '{uart_rxd: 2'b11, ext_intr: 2'b00}, p_in);
    check_en = 1'b1;
    for (int a = 0; a < 16; a += 4) read_reg(test_name, a[APB_AW-1:0], '0, 1'b0);

    // Register access and error responses
    test_name = "apb_regs";
    pad_in = $urandom;
    rnd = $urandom;
    write_reg(test_name, REG_GPIO_DIR, rnd, 1'b0);
    read_reg(test_name, REG_GPIO_DIR, rnd, 1'b0);
    rnd = $urandom;
    write_reg(test_name, REG_GPIO_OUT, rnd, 1'b0);
    read_reg(test_name, REG_GPIO_OUT, rnd, 1'b0);
    rnd = $urandom;
    write_reg(test_name, REG_FUNC_SEL, rnd, 1'b0);
    read_reg(test_name, REG_FUNC_SEL, rnd & 32'h3fff, 1'b0);
    read_reg(test_name, REG_GPIO_IN, pad_in, 1'b0);
    write_reg(test_name, REG_GPIO_IN, ~pad_in, 1'b1);
    read_reg(test_name, REG_GPIO_IN, pad_in, 1'b0);
    write_reg(test_name, 4'h2, $urandom, 1'b1);
    read_reg(test_name, 4'h6, '0, 1'b1);

    // Plain GPIO
    test_name = "gpio_only";
    write_reg(test_name, REG_FUNC_SEL, '0, 1'b0);
    for (int i = 0; i < N_GPIO; i++) begin
      write_reg(test_name, REG_GPIO_DIR, $urandom, 1'b0);
      write_reg(test_name, REG_GPIO_OUT, $urandom, 1'b0);
      rnd = $urandom;
      @(negedge clk);
      p_out = rnd[$bits(periph_out_t)-1:0];
    end

    // Alternate functions with forced overlaps
    test_name = "alt_priority";
    for (int i = 0; i < N_ALT; i++) begin
      rnd = $urandom & 32'h3fff;
      if (i % 4 == 0) rnd = rnd | 32'h3c1e;
      if (i % 4 == 1) rnd = rnd | 32'h03c0;
      write_reg(test_name, REG_FUNC_SEL, rnd, 1'b0);
      write_reg(test_name, REG_GPIO_DIR, $urandom, 1'b0);
      write_reg(test_name, REG_GPIO_OUT, $urandom, 1'b0);
      rnd = $urandom;
      @(negedge clk);
      p_out = rnd[$bits(periph_out_t)-1:0];
    end

    // Synchronizer shows the old value after one edge and the new after two
    test_name = "input_path";
    for (int i = 0; i < N_IN; i++) begin
      write_reg(test_name, REG_FUNC_SEL, $urandom, 1'b0);
      prev = pad_in;
      @(negedge clk);
      pad_in = $urandom;
      @(posedge clk);
      #1;
      check_periph_in(test_name, ref_periph_in(cfg_model, prev), p_in);
      @(posedge clk);
      #1;
      check_periph_in(test_name, ref_periph_in(cfg_model, pad_in), p_in);
      read_reg(test_name, REG_GPIO_IN, pad_in, 1'b0);
    end

    $display("all tests passed");
    $finish;
  end

endmodule

//--- project.f
+incdir+tests
src/pinmux_pkg.sv
src/pinmux_regs.sv
src/pad_out_mux.sv
src/pad_in_route.sv
src/pinmux_top.sv
tests/pinmux_tb.sv
